/* compile.f */
design/memPkg.sv
design/memReqArbiter.sv
design/memByteEngine.sv
design/memRespPacker.sv
design/memCtrl.sv
sim/ramModel.sv
sim/tbMemCtrl.sv

/* design/memByteEngine.sv */
`timescale 1ns/1ps
`default_nettype none

module memByteEngine
    import memPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     i_ioFull,
    input  logic     i_start,
    input  memReq_t  i_grant,
    output memPort_t o_memPort,
    output beat_t    o_beat
);

    logic              busy;
    logic [BEAT_W-1:0] idxQ;
    logic [BEAT_W-1:0] curIdx;
    logic [BEAT_W-1:0] lastIdx;
    logic              active;
    logic              isLast;

    // length code to index of the final byte
    always_comb begin
        case (i_grant.len)
            LEN_BYTE: lastIdx = 2'd0;
            LEN_HALF: lastIdx = 2'd1;
            LEN_WORD: lastIdx = BEAT_W'(WORD_BYTES - 1);
            default:  lastIdx = BEAT_W'(WORD_BYTES - 1);
        endcase
    end

    // byte 0 goes out in the start cycle itself
    assign active = busy || i_start;
    assign curIdx = busy ? idxQ : '0;
    assign isLast = (curIdx == lastIdx);

    // RAM port
    // address and data follow held state, so they stay put in a stall
    always_comb begin
        o_memPort.addr  = i_grant.addr + ADDR_W'(curIdx);
        o_memPort.wdata = i_grant.wdata[curIdx*BYTE_W +: BYTE_W];
        o_memPort.write = active && i_grant.isWrite && !i_ioFull;
    end

    // beat note for the packer
    // a store reports only its final byte
    always_comb begin
        o_beat.valid   = active && !i_ioFull && (!i_grant.isWrite || isLast);
        o_beat.idx     = curIdx;
        o_beat.last    = isLast;
        o_beat.isWrite = i_grant.isWrite;
    end

    // byte stepper
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            idxQ <= '0;
        end else if (!i_ioFull && active) begin
            busy <= !isLast;
            idxQ <= curIdx + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/memCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module memCtrl
    import memPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              i_ioFull,
    // instruction fetch port
    input  logic              i_fetchReq,
    input  logic [ADDR_W-1:0] i_fetchAddr,
    output logic              o_fetchAck,
    output logic [WORD_W-1:0] o_fetchInst,
    // load and store port
    input  logic              i_dataReq,
    input  dataCmd_t          i_dataCmd,
    output logic              o_dataAck,
    output logic [WORD_W-1:0] o_dataRdata,
    // byte RAM
    input  logic [BYTE_W-1:0] i_memData,
    output memPort_t          o_memPort
);

    memReq_t           grant;
    logic              start;
    logic              done;
    logic [WORD_W-1:0] word;
    beat_t             beat;

    memReqArbiter arb0 (
        .clk         (clk),
        .rst         (rst),
        .i_ioFull    (i_ioFull),
        .i_fetchReq  (i_fetchReq),
        .i_fetchAddr (i_fetchAddr),
        .i_dataReq   (i_dataReq),
        .i_dataCmd   (i_dataCmd),
        .i_done      (done),
        .i_word      (word),
        .o_fetchAck  (o_fetchAck),
        .o_fetchInst (o_fetchInst),
        .o_dataAck   (o_dataAck),
        .o_dataRdata (o_dataRdata),
        .o_grant     (grant),
        .o_start     (start)
    );

    memByteEngine eng0 (
        .clk       (clk),
        .rst       (rst),
        .i_ioFull  (i_ioFull),
        .i_start   (start),
        .i_grant   (grant),
        .o_memPort (o_memPort),
        .o_beat    (beat)
    );

    memRespPacker pack0 (
        .clk       (clk),
        .rst       (rst),
        .i_ioFull  (i_ioFull),
        .i_start   (start),
        .i_beat    (beat),
        .i_memData (i_memData),
        .o_done    (done),
        .o_word    (word)
    );

endmodule

`default_nettype wire

/* design/memPkg.sv */
`default_nettype none

package memPkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int BYTE_W = 8;
    localparam int BEAT_W = 2;

    // bytes in a full word
    localparam int WORD_BYTES = WORD_W / BYTE_W;

    // access length of a request
    typedef enum logic [1:0] {
        LEN_BYTE = 2'd0,
        LEN_HALF = 2'd1,
        LEN_WORD = 2'd2
    } lenSel_t;

    // data port request
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
        lenSel_t           len;
        logic              isWrite;
    } dataCmd_t;

    // request granted by the arbiter
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
        lenSel_t           len;
        logic              isWrite;
        logic              isFetch;
    } memReq_t;

    // byte-wide RAM port
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [BYTE_W-1:0] wdata;
        logic              write;
    } memPort_t;

    // one byte step, engine to packer
    typedef struct packed {
        logic              valid;
        logic [BEAT_W-1:0] idx;
        logic              last;
        logic              isWrite;
    } beat_t;

endpackage

`default_nettype wire

/* design/memReqArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module memReqArbiter
    import memPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              i_ioFull,
    input  logic              i_fetchReq,
    input  logic [ADDR_W-1:0] i_fetchAddr,
    input  logic              i_dataReq,
    input  dataCmd_t          i_dataCmd,
    input  logic              i_done,
    input  logic [WORD_W-1:0] i_word,
    output logic              o_fetchAck,
    output logic [WORD_W-1:0] o_fetchInst,
    output logic              o_dataAck,
    output logic [WORD_W-1:0] o_dataRdata,
    output memReq_t           o_grant,
    output logic              o_start
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_ACK,
        ST_REL
    } arbState_t;

    arbState_t state;
    logic      grantedReq;

    // req line of the port that owns the grant
    assign grantedReq = o_grant.isFetch ? i_fetchReq : i_dataReq;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            o_start    <= 1'b0;
            o_fetchAck <= 1'b0;
            o_dataAck  <= 1'b0;
        end else if (!i_ioFull) begin
            o_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_dataReq || i_fetchReq) begin
                        o_start <= 1'b1;
                        state   <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (i_done) begin
                        if (o_grant.isFetch) begin
                            o_fetchAck <= 1'b1;
                        end else begin
                            o_dataAck <= 1'b1;
                        end
                        state <= ST_ACK;
                    end
                end
                // hold the ack until the requester lets go
                ST_ACK: begin
                    if (!grantedReq) begin
                        o_fetchAck <= 1'b0;
                        o_dataAck  <= 1'b0;
                        state      <= ST_REL;
                    end
                end
                ST_REL: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // granted request and response words
    always_ff @(posedge clk) begin
        if (!i_ioFull) begin
            if (state == ST_IDLE) begin
                // data side wins a tie
                if (i_dataReq) begin
                    o_grant.addr    <= i_dataCmd.addr;
                    o_grant.wdata   <= i_dataCmd.wdata;
                    o_grant.len     <= i_dataCmd.len;
                    o_grant.isWrite <= i_dataCmd.isWrite;
                    o_grant.isFetch <= 1'b0;
                end else if (i_fetchReq) begin
                    o_grant.addr    <= i_fetchAddr;
                    o_grant.wdata   <= '0;
                    o_grant.len     <= LEN_WORD;
                    o_grant.isWrite <= 1'b0;
                    o_grant.isFetch <= 1'b1;
                end
            end
            if (state == ST_BUSY && i_done) begin
                if (o_grant.isFetch) begin
                    o_fetchInst <= i_word;
                end else begin
                    o_dataRdata <= i_word;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/memRespPacker.sv */
`timescale 1ns/1ps
`default_nettype none

module memRespPacker
    import memPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              i_ioFull,
    input  logic              i_start,
    input  beat_t             i_beat,
    input  logic [BYTE_W-1:0] i_memData,
    output logic              o_done,
    output logic [WORD_W-1:0] o_word
);

    beat_t beatQ;
    logic  fire;

    // delayed beat lines up with the read byte
    assign fire = beatQ.valid && beatQ.last;

    // beats are never valid in a stall, so the delay stage runs every cycle
    // and done is kept up until the arbiter can see it
    always_ff @(posedge clk) begin
        if (rst) begin
            beatQ  <= '0;
            o_done <= 1'b0;
        end else begin
            beatQ  <= i_beat;
            o_done <= fire || (o_done && i_ioFull);
        end
    end

    // assemble the little-endian word
    always_ff @(posedge clk) begin
        if (i_start) begin
            o_word <= '0;
        end else if (beatQ.valid && !beatQ.isWrite) begin
            o_word[beatQ.idx*BYTE_W +: BYTE_W] <= i_memData;
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f compile.f --top-module tbMemCtrl -o simMemCtrl \
    && ./obj_dir/simMemCtrl | tee sim.log \
    || { echo "build or run error"; exit 1; }

grep -q "Simulation completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

/* sim/ramModel.sv */
`timescale 1ns/1ps
`default_nettype none

module ramModel
    import memPkg::*;
(
    input  logic              clk,
    input  memPort_t          i_port,
    output logic [BYTE_W-1:0] o_rdata
);

    // 64 KiB of bytes, upper address bits ignored
    logic [BYTE_W-1:0] mem [0:65535];
    logic [15:0]       idx;

    assign idx = i_port.addr[15:0];

    // read byte comes back one cycle after its address
    always @(posedge clk) begin
        if (i_port.write) begin
            mem[idx] <= i_port.wdata;
        end
        o_rdata <= mem[idx];
    end

endmodule

`default_nettype wire

/* sim/tbMemCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMemCtrl
    import memPkg::*;
();

    logic              clk;
    logic              rst;
    logic              ioFull;
    logic              fetchReq;
    logic [ADDR_W-1:0] fetchAddr;
    logic              fetchAck;
    logic [WORD_W-1:0] fetchInst;
    logic              dataReq;
    dataCmd_t          dataCmd;
    logic              dataAck;
    logic [WORD_W-1:0] dataRdata;
    logic [BYTE_W-1:0] memData;
    memPort_t          memPort;

    // expected RAM contents
    logic [BYTE_W-1:0] refMem [0:65535];
    int                valueErrors;
    int                ruleErrors;
    int                timeouts;
    logic              prevFetchAck;
    logic              prevDataAck;

    memCtrl dut0 (
        .clk         (clk),
        .rst         (rst),
        .i_ioFull    (ioFull),
        .i_fetchReq  (fetchReq),
        .i_fetchAddr (fetchAddr),
        .o_fetchAck  (fetchAck),
        .o_fetchInst (fetchInst),
        .i_dataReq   (dataReq),
        .i_dataCmd   (dataCmd),
        .o_dataAck   (dataAck),
        .o_dataRdata (dataRdata),
        .i_memData   (memData),
        .o_memPort   (memPort)
    );

    ramModel ram0 (
        .clk     (clk),
        .i_port  (memPort),
        .o_rdata (memData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            valueErrors++;
            $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic flagRule(input string what);
        ruleErrors++;
        $display("protocol error at %0t: %s", $time, what);
    endtask

    task automatic endRun();
        $display("errors: value %0d, protocol %0d, timeout %0d", valueErrors, ruleErrors, timeouts);
        if (valueErrors + ruleErrors + timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    function automatic int nBytesOf(input lenSel_t len);
        case (len)
            LEN_BYTE: return 1;
            LEN_HALF: return 2;
            default:  return 4;
        endcase
    endfunction

    // little-endian bytes from the reference array, zero above n
    function automatic logic [31:0] expectLoad(input logic [31:0] addr, input int n);
        logic [31:0] w;
        logic [15:0] a;
        w = '0;
        for (int k = 0; k < n; k++) begin
            a = addr[15:0] + 16'(k);
            w = w | (32'(refMem[a]) << (8 * k));
        end
        return w;
    endfunction

    task automatic waitAck(input bit onData, input logic level);
        int   cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < 200) begin
            @(posedge clk);
            cycles++;
            seen = ((onData ? dataAck : fetchAck) == level);
        end
        if (!seen) begin
            timeouts++;
            $display("%s ack never went to %0b", onData ? "data" : "fetch", level);
            endRun();
        end
    endtask

    task automatic fetchWord(input logic [31:0] addr);
        @(posedge clk);
        #1;
        fetchAddr = addr;
        fetchReq = 1'b1;
        waitAck(1'b0, 1'b1);
        checkValue("o_fetchInst", fetchInst, expectLoad(addr, 4));
        #1;
        fetchReq = 1'b0;
        waitAck(1'b0, 1'b0);
    endtask

    // one data handshake, optionally with an I/O stall after stallAfter edges
    task automatic dataAccess(input logic [31:0] addr, input logic [31:0] wdata,
                              input lenSel_t len, input logic isWrite, input int stallAfter,
                              input int stallCycles, output logic [31:0] rdata);
        @(posedge clk);
        #1;
        dataCmd.addr = addr;
        dataCmd.wdata = wdata;
        dataCmd.len = len;
        dataCmd.isWrite = isWrite;
        dataReq = 1'b1;
        if (stallCycles > 0) begin
            repeat (stallAfter) @(posedge clk);
            #1;
            ioFull = 1'b1;
            repeat (stallCycles) begin
                @(posedge clk);
                assert (!dataAck) else flagRule("data ack rose during an I/O stall");
            end
            #1;
            ioFull = 1'b0;
        end
        waitAck(1'b1, 1'b1);
        rdata = dataRdata;
        #1;
        dataReq = 1'b0;
        waitAck(1'b1, 1'b0);
    endtask

    task automatic loadCheck(input logic [31:0] addr, input lenSel_t len);
        logic [31:0] rdata;
        dataAccess(addr, 32'h0, len, 1'b0, 0, 0, rdata);
        checkValue("o_dataRdata", rdata, expectLoad(addr, nBytesOf(len)));
    endtask

    task automatic storeCheck(input logic [31:0] addr, input lenSel_t len,
                              input logic [31:0] wdata, input int stallAfter,
                              input int stallCycles);
        logic [31:0] rdata;
        logic [15:0] a;
        logic [7:0]  expByte;
        int          n;
        n = nBytesOf(len);
        dataAccess(addr, wdata, len, 1'b1, stallAfter, stallCycles, rdata);
        checkValue("o_dataRdata", rdata, 32'h0);
        // written bytes plus one neighbor on each side
        for (int k = -1; k <= 4; k++) begin
            a = addr[15:0] + 16'(k);
            if (k >= 0 && k < n) begin
                expByte = 8'(wdata >> (8 * k));
            end else begin
                expByte = refMem[a];
            end
            checkValue($sformatf("ram0.mem[%h]", a), 32'(ram0.mem[a]), 32'(expByte));
        end
        for (int k = 0; k < n; k++) begin
            a = addr[15:0] + 16'(k);
            refMem[a] = 8'(wdata >> (8 * k));
        end
        loadCheck(addr, LEN_WORD);
    endtask

    task automatic dualRequest(input logic [31:0] fAddr, input logic [31:0] dAddr);
        int cycles;
        @(posedge clk);
        #1;
        fetchAddr = fAddr;
        fetchReq = 1'b1;
        dataCmd.addr = dAddr;
        dataCmd.wdata = 32'h0;
        dataCmd.len = LEN_WORD;
        dataCmd.isWrite = 1'b0;
        dataReq = 1'b1;
        cycles = 0;
        while (!dataAck && !fetchAck && cycles < 200) begin
            @(posedge clk);
            cycles++;
        end
        if (!dataAck && !fetchAck) begin
            timeouts++;
            $display("neither ack rose after a tied request");
            endRun();
        end
        assert (dataAck && !fetchAck) else flagRule("fetch ack came first on a tie");
        checkValue("o_dataRdata", dataRdata, expectLoad(dAddr, 4));
        #1;
        dataReq = 1'b0;
        waitAck(1'b1, 1'b0);
        waitAck(1'b0, 1'b1);
        checkValue("o_fetchInst", fetchInst, expectLoad(fAddr, 4));
        #1;
        fetchReq = 1'b0;
        waitAck(1'b0, 1'b0);
    endtask

    // four-phase rules and the stall write rule, every cycle
    always @(posedge clk) begin
        if (rst) begin
            prevFetchAck <= 1'b0;
            prevDataAck <= 1'b0;
        end else begin
            assert (!(fetchAck && !prevFetchAck) || fetchReq)
                else flagRule("fetch ack rose while fetch req was low");
            assert (!(!fetchAck && prevFetchAck) || !fetchReq)
                else flagRule("fetch ack fell while fetch req was high");
            assert (!(dataAck && !prevDataAck) || dataReq)
                else flagRule("data ack rose while data req was low");
            assert (!(!dataAck && prevDataAck) || !dataReq)
                else flagRule("data ack fell while data req was high");
            assert (!(ioFull && memPort.write)) else flagRule("write strobe high during a stall");
            prevFetchAck <= fetchAck;
            prevDataAck <= dataAck;
        end
    end

    initial begin
        logic [15:0] a;
        logic [7:0]  b;
        logic [31:0] rAddr;
        lenSel_t     rLen;
        rst = 1'b1;
        ioFull = 1'b0;
        fetchReq = 1'b0;
        fetchAddr = '0;
        dataReq = 1'b0;
        dataCmd = '0;
        valueErrors = 0;
        ruleErrors = 0;
        timeouts = 0;
        void'($urandom(32'hefc5e0a9));
        for (int i = 0; i < 65536; i++) begin
            a = 16'(i);
            b = 8'($urandom);
            refMem[a] = b;
            ram0.mem[a] = b;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        assert (!fetchAck && !dataAck && !memPort.write)
            else flagRule("ack or write strobe high after reset");

        fetchWord(32'h0000_0100);
        fetchWord(32'h0000_0a37);
        fetchWord(32'h0000_fff0);
        for (int l = 0; l < 3; l++) begin
            loadCheck(32'h0000_0200 + 32'(l * 5), lenSel_t'(2'(l)));
            loadCheck(32'h0000_3003 + 32'(l * 7), lenSel_t'(2'(l)));
        end
        storeCheck(32'h0000_4000, LEN_BYTE, 32'h1122_33a5, 0, 0);
        storeCheck(32'h0000_4011, LEN_HALF, 32'h5566_c3d2, 0, 0);
        storeCheck(32'h0000_4022, LEN_WORD, 32'hdead_beef, 0, 0);
        dualRequest(32'h0000_0500, 32'h0000_0600);
        // stall lands after the first store byte and outlasts the unstalled ack time
        storeCheck(32'h0000_4100, LEN_WORD, 32'h0bad_f00d, 2, 8);

        repeat (12) begin
            rAddr = 32'h0000_1000 + ($urandom % 32'h1000);
            rLen = lenSel_t'(2'($urandom % 3));
            if ($urandom % 2 == 0) begin
                storeCheck(rAddr, rLen, $urandom, 0, 0);
            end else begin
                loadCheck(rAddr, rLen);
            end
            fetchWord(rAddr + 32'h0000_0800);
        end
        repeat (3) @(posedge clk);
        endRun();
    end

endmodule

`default_nettype wire
